//--- design/xv_pkg.sv
// ----------------------------------------------------------------------
// shared constants, types and structs of the 640x480 video generator
// ----------------------------------------------------------------------
package xv_pkg;

    // vector types with a meaning
    typedef logic [15:0] word_t;        // register and vram data word
    typedef logic [15:0] addr_t;        // vram word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [9:0]  hres_t;        // horizontal count
    typedef logic [9:0]  vres_t;        // vertical count
    typedef logic [5:0]  reg_num_t;     // register number
    typedef logic [3:0]  intr_t;        // interrupt lines

    // horizontal timing, visible pixels first
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;   // 800

    // vertical timing, visible lines first
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;   // 525

    // counter position to pixel at the outputs
    localparam int PIXEL_LATENCY = 3;

    localparam color_t BORDER_RESET   = 8'h08;     // dark grey
    localparam word_t  LINE_LEN_RESET = 16'd320;   // 640 pixels at 8 bpp

    // register numbers
    localparam reg_num_t XR_VID_CTRL     = 6'h00;
    localparam reg_num_t XR_SCANLINE     = 6'h08;
    localparam reg_num_t XR_PA_GFX_CTRL  = 6'h10;
    localparam reg_num_t XR_PA_DISP_ADDR = 6'h12;
    localparam reg_num_t XR_PA_LINE_LEN  = 6'h13;

    // playfield configuration
    typedef struct packed {
        logic   blank;          // show border only
        color_t colorbase;      // xor'd into every pixel
        addr_t  start_addr;     // first word of the frame
        word_t  line_len;       // words per line
    } pf_cfg_t;

    // raster position and events
    typedef struct packed {
        hres_t h_count;
        vres_t v_count;
        logic  h_visible;
        logic  v_visible;
        logic  end_of_line;     // last pixel of any line
        logic  end_of_frame;    // last pixel of last line
        logic  end_of_visible;  // last pixel of last visible line
    } vid_pos_t;

endpackage

//--- design/video_timing.sv
// ----------------------------------------------------------------------
// raster timing for 640x480, counters, sync and frame events
// sync outputs delayed to line up with the pixel pipeline
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module video_timing (
    input  logic               clk,
    input  logic               reset_i,
    output xv_pkg::vid_pos_t   pos_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o,
    output logic               h_blank_o,
    output logic               v_blank_o
);

    xv_pkg::hres_t h_count;
    xv_pkg::vres_t v_count;
    logic          h_visible;
    logic          v_visible;
    logic          end_of_line;
    logic          hsync;
    logic          vsync;
    logic [4:0]    sync_now;    // hsync, vsync, de, h_blank, v_blank

    // one stage per cycle of pixel latency
    logic [xv_pkg::PIXEL_LATENCY-1:0][4:0] sync_pipe;

    assign h_visible   = h_count < xv_pkg::hres_t'(xv_pkg::H_VISIBLE);
    assign v_visible   = v_count < xv_pkg::vres_t'(xv_pkg::V_VISIBLE);
    assign end_of_line = h_count == xv_pkg::hres_t'(xv_pkg::H_TOTAL - 1);

    assign hsync = (h_count >= xv_pkg::hres_t'(xv_pkg::H_VISIBLE + xv_pkg::H_FRONT)) &&
                   (h_count <  xv_pkg::hres_t'(xv_pkg::H_VISIBLE + xv_pkg::H_FRONT +
                                               xv_pkg::H_SYNC));
    assign vsync = (v_count >= xv_pkg::vres_t'(xv_pkg::V_VISIBLE + xv_pkg::V_FRONT)) &&
                   (v_count <  xv_pkg::vres_t'(xv_pkg::V_VISIBLE + xv_pkg::V_FRONT +
                                               xv_pkg::V_SYNC));

    always_comb begin
        pos_o.h_count        = h_count;
        pos_o.v_count        = v_count;
        pos_o.h_visible      = h_visible;
        pos_o.v_visible      = v_visible;
        pos_o.end_of_line    = end_of_line;
        pos_o.end_of_frame   = end_of_line && (v_count == xv_pkg::vres_t'(xv_pkg::V_TOTAL - 1));
        pos_o.end_of_visible = end_of_line && (v_count == xv_pkg::vres_t'(xv_pkg::V_VISIBLE - 1));
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (end_of_line) begin
            h_count <= '0;
            if (v_count == xv_pkg::vres_t'(xv_pkg::V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign sync_now = {hsync, vsync, h_visible && v_visible, !h_visible, !v_visible};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_pipe <= {xv_pkg::PIXEL_LATENCY{5'b00011}};    // blanked, no sync
        end else begin
            sync_pipe <= {sync_pipe[xv_pkg::PIXEL_LATENCY-2:0], sync_now};
        end
    end

    assign hsync_o   = sync_pipe[xv_pkg::PIXEL_LATENCY-1][4];
    assign vsync_o   = sync_pipe[xv_pkg::PIXEL_LATENCY-1][3];
    assign dv_de_o   = sync_pipe[xv_pkg::PIXEL_LATENCY-1][2];
    assign h_blank_o = sync_pipe[xv_pkg::PIXEL_LATENCY-1][1];
    assign v_blank_o = sync_pipe[xv_pkg::PIXEL_LATENCY-1][0];

endmodule

//--- design/vgen_regs.sv
// ----------------------------------------------------------------------
// video config registers, write decode, read-back and interrupt pulses
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module vgen_regs (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               vgen_reg_wr_en_i,
    input  xv_pkg::reg_num_t   vgen_reg_num_i,
    input  xv_pkg::word_t      vgen_reg_data_i,
    input  xv_pkg::intr_t      intr_status_i,
    input  xv_pkg::vres_t      v_count_i,
    input  logic               end_of_visible_i,
    output xv_pkg::word_t      vgen_reg_data_o,
    output xv_pkg::intr_t      intr_signal_o,
    output xv_pkg::color_t     border_color_o,
    output xv_pkg::pf_cfg_t    pf_cfg_o
);

    xv_pkg::color_t  border_color;
    xv_pkg::pf_cfg_t pf_cfg;
    xv_pkg::word_t   rd_data;

    // register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color      <= xv_pkg::BORDER_RESET;
            pf_cfg.blank      <= 1'b1;                  // playfield starts blanked
            pf_cfg.colorbase  <= '0;
            pf_cfg.start_addr <= '0;
            pf_cfg.line_len   <= xv_pkg::LINE_LEN_RESET;
        end else if (vgen_reg_wr_en_i) begin
            case (vgen_reg_num_i)
                xv_pkg::XR_VID_CTRL: begin
                    border_color <= vgen_reg_data_i[15:8];
                end
                xv_pkg::XR_PA_GFX_CTRL: begin
                    pf_cfg.colorbase <= vgen_reg_data_i[15:8];
                    pf_cfg.blank     <= vgen_reg_data_i[7];
                end
                xv_pkg::XR_PA_DISP_ADDR: begin
                    pf_cfg.start_addr <= vgen_reg_data_i;
                end
                xv_pkg::XR_PA_LINE_LEN: begin
                    pf_cfg.line_len <= vgen_reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    // interrupt lines only ever high for one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o <= '0;
        end else begin
            intr_signal_o <= '0;
            if (vgen_reg_wr_en_i && vgen_reg_num_i == xv_pkg::XR_VID_CTRL) begin
                intr_signal_o <= vgen_reg_data_i[3:0];     // software raised
            end
            if (end_of_visible_i) begin
                intr_signal_o[3] <= 1'b1;                 // vertical blank start
            end
        end
    end

    // read-back select
    always_comb begin
        case (vgen_reg_num_i)
            xv_pkg::XR_VID_CTRL:     rd_data = {border_color, 4'b0, intr_status_i};
            xv_pkg::XR_SCANLINE:     rd_data = xv_pkg::word_t'(v_count_i);
            xv_pkg::XR_PA_GFX_CTRL:  rd_data = {pf_cfg.colorbase, pf_cfg.blank, 7'b0};
            xv_pkg::XR_PA_DISP_ADDR: rd_data = pf_cfg.start_addr;
            xv_pkg::XR_PA_LINE_LEN:  rd_data = pf_cfg.line_len;
            default:                 rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        vgen_reg_data_o <= rd_data;     // one cycle read latency
    end

    assign border_color_o = border_color;
    assign pf_cfg_o       = pf_cfg;

endmodule

//--- design/bitmap_playfield.sv
// ----------------------------------------------------------------------
// 8 bpp bitmap playfield, one vram word per pixel pair
// border color shown outside the visible area and while blanked
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module bitmap_playfield (
    input  logic               clk,
    input  logic               reset_i,
    input  xv_pkg::vid_pos_t   pos_i,
    input  xv_pkg::pf_cfg_t    cfg_i,
    input  xv_pkg::color_t     border_color_i,
    input  xv_pkg::word_t      vram_data_i,
    output logic               vram_sel_o,
    output xv_pkg::addr_t      vram_addr_o,
    output xv_pkg::color_t     color_index_o
);

    xv_pkg::addr_t  line_addr;      // first word of current line
    logic           fetch_now;      // visible pixel of an enabled playfield
    logic           fetch_d1;
    logic           odd_d1;
    xv_pkg::word_t  pix_word;       // word of the current pixel pair
    xv_pkg::color_t pix_next;

    // line address steps once per visible line, reloads per frame
    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
        end else if (pos_i.end_of_frame) begin
            line_addr <= cfg_i.start_addr;
        end else if (pos_i.end_of_line && pos_i.v_visible) begin
            line_addr <= line_addr + cfg_i.line_len;
        end
    end

    assign fetch_now   = pos_i.h_visible && pos_i.v_visible && !cfg_i.blank;
    assign vram_sel_o  = fetch_now && !pos_i.h_count[0];   // even x only
    assign vram_addr_o = line_addr + xv_pkg::addr_t'(pos_i.h_count[9:1]);

    // stage 1, read data arrives from vram
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_d1 <= 1'b0;
            odd_d1   <= 1'b0;
        end else begin
            fetch_d1 <= fetch_now;
            odd_d1   <= pos_i.h_count[0];
        end
    end

    // keep the word for the odd pixel that follows
    always_ff @(posedge clk) begin
        if (fetch_d1 && !odd_d1) begin
            pix_word <= vram_data_i;
        end
    end

    always_comb begin
        if (!fetch_d1) begin
            pix_next = border_color_i;
        end else if (odd_d1) begin
            pix_next = pix_word[7:0] ^ cfg_i.colorbase;       // low byte, odd x
        end else begin
            pix_next = vram_data_i[15:8] ^ cfg_i.colorbase;   // high byte first
        end
    end

    // stage 2, pixel index
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else begin
            color_index_o <= pix_next;
        end
    end

endmodule

//--- design/video_gen.sv
// ----------------------------------------------------------------------
// video generator top, timing, config registers and bitmap playfield
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module video_gen (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               vgen_reg_wr_en_i,
    input  xv_pkg::reg_num_t   vgen_reg_num_i,
    input  xv_pkg::word_t      vgen_reg_data_i,
    input  xv_pkg::intr_t      intr_status_i,
    input  xv_pkg::word_t      vram_data_i,
    output xv_pkg::word_t      vgen_reg_data_o,
    output xv_pkg::intr_t      intr_signal_o,
    output logic               vram_sel_o,
    output xv_pkg::addr_t      vram_addr_o,
    output xv_pkg::color_t     color_index_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o,
    output logic               h_blank_o,
    output logic               v_blank_o
);

    xv_pkg::vid_pos_t pos;
    xv_pkg::pf_cfg_t  pf_cfg;
    xv_pkg::color_t   border_color;
    xv_pkg::color_t   pf_color_index;

    video_timing timing_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .pos_o     (pos),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .dv_de_o   (dv_de_o),
        .h_blank_o (h_blank_o),
        .v_blank_o (v_blank_o)
    );

    vgen_regs regs_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .vgen_reg_wr_en_i (vgen_reg_wr_en_i),
        .vgen_reg_num_i   (vgen_reg_num_i),
        .vgen_reg_data_i  (vgen_reg_data_i),
        .intr_status_i    (intr_status_i),
        .v_count_i        (pos.v_count),
        .end_of_visible_i (pos.end_of_visible),
        .vgen_reg_data_o  (vgen_reg_data_o),
        .intr_signal_o    (intr_signal_o),
        .border_color_o   (border_color),
        .pf_cfg_o         (pf_cfg)
    );

    bitmap_playfield pf_a_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .pos_i          (pos),
        .cfg_i          (pf_cfg),
        .border_color_i (border_color),
        .vram_data_i    (vram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .color_index_o  (pf_color_index)
    );

    // last pixel stage toward the output
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else begin
            color_index_o <= pf_color_index;
        end
    end

endmodule

//--- verification/video_gen_props.sv
// ----------------------------------------------------------------------
// concurrent checks on the video generator, bound into video_gen
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module video_gen_props (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               vgen_reg_wr_en_i,
    input  xv_pkg::reg_num_t   vgen_reg_num_i,
    input  xv_pkg::word_t      vgen_reg_data_i,
    input  xv_pkg::intr_t      intr_status_i,
    input  xv_pkg::word_t      vgen_reg_data_o,
    input  xv_pkg::intr_t      intr_signal_o,
    input  logic               vram_sel_o,
    input  xv_pkg::color_t     color_index_o,
    input  logic               hsync_o,
    input  logic               vsync_o,
    input  logic               dv_de_o,
    input  logic               h_blank_o,
    input  logic               v_blank_o,
    input  xv_pkg::vid_pos_t   pos
);

    int             err_reset = 0;
    int             err_rdback = 0;
    int             err_intr = 0;
    int             err_border = 0;
    int             err_sync = 0;
    int             prop_errors;      // read by the testbench
    int             hs_run;           // consecutive hsync cycles
    int             de_run;           // consecutive display enable cycles
    int             hb_run;           // consecutive horizontal blank cycles
    int             vb_run;           // consecutive vertical blank cycles
    logic           ctrl_wr;
    logic           blank_set;        // blank bit as last written
    xv_pkg::color_t border_set;       // border color as last written

    assign ctrl_wr     = vgen_reg_wr_en_i && vgen_reg_num_i == xv_pkg::XR_VID_CTRL;
    assign prop_errors = err_reset + err_rdback + err_intr + err_border + err_sync;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_run <= 0;
            de_run <= 0;
            hb_run <= 0;
            vb_run <= 0;
        end else begin
            hs_run <= hsync_o ? hs_run + 1 : 0;
            de_run <= dv_de_o ? de_run + 1 : 0;
            hb_run <= h_blank_o ? hb_run + 1 : 0;
            vb_run <= v_blank_o ? vb_run + 1 : 0;
        end
    end

    // register state as seen on the write port
    always_ff @(posedge clk) begin
        if (reset_i) begin
            blank_set  <= 1'b1;
            border_set <= xv_pkg::BORDER_RESET;
        end else if (vgen_reg_wr_en_i) begin
            if (vgen_reg_num_i == xv_pkg::XR_PA_GFX_CTRL) begin
                blank_set <= vgen_reg_data_i[7];
            end
            if (ctrl_wr) begin
                border_set <= vgen_reg_data_i[15:8];
            end
        end
    end

    // every output idle in the cycle after a reset edge
    reset_idle: assert property (@(posedge clk) reset_i |=> !vram_sel_o &&
            intr_signal_o == '0 && !hsync_o && !vsync_o && !dv_de_o && color_index_o == '0)
        else begin
            err_reset++;
            $error("outputs not idle after reset");
        end

    vid_ctrl_read: assert property (@(posedge clk) disable iff (reset_i)
            vgen_reg_num_i == xv_pkg::XR_VID_CTRL |=>
            vgen_reg_data_o == {$past(border_set), 4'h0, $past(intr_status_i)})
        else begin
            err_rdback++;
            $error("video control read-back does not show border color and status");
        end

    soft_intr: assert property (@(posedge clk) disable iff (reset_i) ctrl_wr |=>
            intr_signal_o == ($past(vgen_reg_data_i[3:0]) | {$past(pos.end_of_visible), 3'b000}))
        else begin
            err_intr++;
            $error("interrupt lines do not follow the video control write");
        end

    intr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
            intr_signal_o != '0 && !ctrl_wr && !pos.end_of_visible |=> intr_signal_o == '0)
        else begin
            err_intr++;
            $error("interrupt line held longer than one cycle");
        end

    vblank_intr: assert property (@(posedge clk) disable iff (reset_i)
            pos.end_of_visible |=> intr_signal_o[3] && !pos.v_visible)
        else begin
            err_intr++;
            $error("no vertical interrupt after the last visible pixel");
        end

    vblank_only: assert property (@(posedge clk) disable iff (reset_i)
            intr_signal_o[3] && !$past(ctrl_wr) |-> $past(pos.end_of_visible))
        else begin
            err_intr++;
            $error("vertical interrupt raised away from the end of the visible frame");
        end

    // blanked playfield reads nothing and shows the border
    blank_no_fetch: assert property (@(posedge clk) disable iff (reset_i)
            blank_set |-> !vram_sel_o)
        else begin
            err_border++;
            $error("vram read issued while the playfield is blanked");
        end

    blank_border: assert property (@(posedge clk) disable iff (reset_i)
            dv_de_o && $past(blank_set, 3) |-> color_index_o == $past(border_set, 2))
        else begin
            err_border++;
            $error("blanked pixel does not show the border color");
        end

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
            $fell(hsync_o) |-> hs_run == xv_pkg::H_SYNC)
        else begin
            err_sync++;
            $error("hsync pulse has the wrong width");
        end

    de_width: assert property (@(posedge clk) disable iff (reset_i)
            $fell(dv_de_o) |-> de_run == xv_pkg::H_VISIBLE)
        else begin
            err_sync++;
            $error("display enable has the wrong length on a line");
        end

    // blanking starts one front porch ahead of each sync pulse
    h_front_porch: assert property (@(posedge clk) disable iff (reset_i)
            $rose(hsync_o) |-> hb_run == xv_pkg::H_FRONT)
        else begin
            err_sync++;
            $error("horizontal blank does not lead hsync by the front porch");
        end

    v_front_porch: assert property (@(posedge clk) disable iff (reset_i)
            $rose(vsync_o) |-> vb_run == xv_pkg::V_FRONT * xv_pkg::H_TOTAL)
        else begin
            err_sync++;
            $error("vertical blank does not lead vsync by the front porch");
        end

endmodule

bind video_gen video_gen_props props_i (
    .clk              (clk),
    .reset_i          (reset_i),
    .vgen_reg_wr_en_i (vgen_reg_wr_en_i),
    .vgen_reg_num_i   (vgen_reg_num_i),
    .vgen_reg_data_i  (vgen_reg_data_i),
    .intr_status_i    (intr_status_i),
    .vgen_reg_data_o  (vgen_reg_data_o),
    .intr_signal_o    (intr_signal_o),
    .vram_sel_o       (vram_sel_o),
    .color_index_o    (color_index_o),
    .hsync_o          (hsync_o),
    .vsync_o          (vsync_o),
    .dv_de_o          (dv_de_o),
    .h_blank_o        (h_blank_o),
    .v_blank_o        (v_blank_o),
    .pos              (pos)
);

//--- verification/video_gen_tb.sv
// ----------------------------------------------------------------------
// testbench for the video generator, register access, vram model
// and a pixel checker for the bitmap playfield
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module video_gen_tb;

    localparam int FRAME_CYCLES = xv_pkg::H_TOTAL * xv_pkg::V_TOTAL;

    logic             clk;
    logic             reset_i;
    logic             vgen_reg_wr_en_i;
    xv_pkg::reg_num_t vgen_reg_num_i;
    xv_pkg::word_t    vgen_reg_data_i;
    xv_pkg::intr_t    intr_status_i;
    xv_pkg::word_t    vram_data_i;
    xv_pkg::word_t    vgen_reg_data_o;
    xv_pkg::intr_t    intr_signal_o;
    logic             vram_sel_o;
    xv_pkg::addr_t    vram_addr_o;
    xv_pkg::color_t   color_index_o;
    logic             hsync_o;
    logic             vsync_o;
    logic             dv_de_o;
    logic             h_blank_o;
    logic             v_blank_o;

    integer           seed = 32'h8179_194c;
    int               reg_errors = 0;
    int               pixel_errors = 0;
    int               timeouts = 0;
    xv_pkg::addr_t    exp_start;        // playfield config as written
    xv_pkg::word_t    exp_len;
    xv_pkg::color_t   exp_cb;
    int               check_line;       // second line compared
    logic             check_en;
    logic             armed;            // checking the current frame
    logic             check_done;
    logic             vsync_d;
    int               de_count;         // de cycles since vsync rise

    video_gen dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // vram answers one cycle after a read
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram_addr_o ^ 16'h5a3c;
        end
    end

    function automatic xv_pkg::color_t expected_pixel(input int x, input int y);
        xv_pkg::addr_t addr;
        xv_pkg::word_t word;
        addr = xv_pkg::addr_t'(int'(exp_start) + y * int'(exp_len) + x / 2);
        word = addr ^ 16'h5a3c;
        if (x % 2 == 0) begin
            return word[15:8] ^ exp_cb;     // even pixel, high byte
        end
        return word[7:0] ^ exp_cb;
    endfunction

    // pixel checker, position from de cycles after vsync
    always @(posedge clk) begin
        int             x;
        int             y;
        xv_pkg::color_t want;
        vsync_d <= vsync_o;
        if (reset_i) begin
            armed      <= 1'b0;
            check_done <= 1'b0;
            de_count   <= 0;
        end else if (vsync_o && !vsync_d) begin
            de_count <= 0;
            armed    <= check_en && !check_done;
        end else if (dv_de_o) begin
            x = de_count % xv_pkg::H_VISIBLE;
            y = de_count / xv_pkg::H_VISIBLE;
            if (armed && (y == 0 || y == check_line)) begin
                want = expected_pixel(x, y);
                assert (color_index_o == want) else begin
                    pixel_errors++;
                    $display("ERR %0t: pixel (%0d,%0d) is %02h, expected %02h",
                             $time, x, y, color_index_o, want);
                end
                if (y == check_line && x == xv_pkg::H_VISIBLE - 1) begin
                    check_done <= 1'b1;
                    armed      <= 1'b0;
                end
            end
            de_count <= de_count + 1;
        end
    end

    task automatic write_reg(input xv_pkg::reg_num_t num, input xv_pkg::word_t data);
        @(posedge clk);
        vgen_reg_wr_en_i <= 1'b1;
        vgen_reg_num_i   <= num;
        vgen_reg_data_i  <= data;
        @(posedge clk);
        vgen_reg_wr_en_i <= 1'b0;
    endtask

    // read data registered one cycle after the select
    task automatic read_reg(input xv_pkg::reg_num_t num, output xv_pkg::word_t data);
        vgen_reg_num_i <= num;
        @(posedge clk);
        @(posedge clk);
        data = vgen_reg_data_o;
    endtask

    task automatic compare_word(input string what, input xv_pkg::word_t got,
                                input xv_pkg::word_t want);
        assert (got == want) else begin
            reg_errors++;
            $display("ERR %0t: %s read back %04h, expected %04h", $time, what, got, want);
        end
    endtask

    task automatic wait_vsync_rise(input int limit);
        logic prev;
        int   n;
        prev = vsync_o;
        for (n = 0; n < limit; n++) begin
            @(posedge clk);
            if (vsync_o && !prev) begin
                break;
            end
            prev = vsync_o;
        end
        if (n == limit) begin
            timeouts++;
            $display("timeout: vsync did not rise within %0d cycles", limit);
        end
    endtask

    task automatic wait_check_done(input int limit);
        int n;
        for (n = 0; n < limit; n++) begin
            @(posedge clk);
            if (check_done) begin
                break;
            end
        end
        if (n == limit) begin
            timeouts++;
            $display("timeout: pixel checker did not finish within %0d cycles", limit);
        end
    endtask

    initial begin
        xv_pkg::word_t rd;
        xv_pkg::word_t wd;
        xv_pkg::intr_t status;
        reset_i          = 1'b1;
        vgen_reg_wr_en_i = 1'b0;
        vgen_reg_num_i   = '0;
        vgen_reg_data_i  = '0;
        intr_status_i    = '0;
        vram_data_i      = '0;
        check_en         = 1'b0;
        check_line       = 1;
        exp_start        = '0;
        exp_len          = '0;
        exp_cb           = '0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < 4; i++) begin
            wd = xv_pkg::word_t'($random(seed));
            write_reg(xv_pkg::XR_PA_DISP_ADDR, wd);
            read_reg(xv_pkg::XR_PA_DISP_ADDR, rd);
            compare_word("display address", rd, wd);
            wd = xv_pkg::word_t'($random(seed));
            write_reg(xv_pkg::XR_PA_LINE_LEN, wd);
            read_reg(xv_pkg::XR_PA_LINE_LEN, rd);
            compare_word("line length", rd, wd);
        end

        // border color plus a software interrupt pulse
        status = xv_pkg::intr_t'($random(seed));
        intr_status_i <= status;
        wd = xv_pkg::word_t'($random(seed));
        write_reg(xv_pkg::XR_VID_CTRL, wd);
        read_reg(xv_pkg::XR_VID_CTRL, rd);
        compare_word("video control", rd, {wd[15:8], 4'h0, status});

        wait_vsync_rise(2 * FRAME_CYCLES);     // one frame of border only

        exp_start  = xv_pkg::addr_t'($random(seed));
        exp_len    = xv_pkg::word_t'($random(seed));
        exp_cb     = xv_pkg::color_t'($random(seed));
        check_line = 1 + int'($unsigned($random(seed)) % (xv_pkg::V_VISIBLE - 1));
        write_reg(xv_pkg::XR_PA_DISP_ADDR, exp_start);
        write_reg(xv_pkg::XR_PA_LINE_LEN, exp_len);
        write_reg(xv_pkg::XR_PA_GFX_CTRL, {exp_cb, 8'h00});     // blank cleared
        check_en <= 1'b1;
        wait_check_done(4 * FRAME_CYCLES);

        repeat (2) @(posedge clk);
        $display("errors: register %0d, pixel %0d, assertion %0d, timeout %0d",
                 reg_errors, pixel_errors, dut_i.props_i.prop_errors, timeouts);
        if (reg_errors + pixel_errors + dut_i.props_i.prop_errors + timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- video_gen.f
design/xv_pkg.sv
design/video_timing.sv
design/vgen_regs.sv
design/bitmap_playfield.sv
design/video_gen.sv
verification/video_gen_props.sv
verification/video_gen_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = video_gen_tb
FILELIST  = video_gen.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
